//--- i2c_bus_pkg.sv
package i2c_bus_pkg;

    // data bits before each acknowledge slot
    localparam int BITS_PER_BYTE = 8;

    // last bit of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // where a serial frame currently is
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,   // waiting to pull sda while scl high
        PH_BYTE,    // eight data bits
        PH_ACK,     // ninth clock
        PH_STOP
    } bus_phase_t;

endpackage

//--- eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;     // page bits plus word address
    localparam int DATA_W = 8;

    // upper address bits travel in the control byte
    localparam int PAGE_W = 3;

    localparam int MEM_DEPTH = 2048;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;  // serial eeprom family code

endpackage

//--- eeprom_wr.sv
`timescale 1ns/10ps

module eeprom_wr (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          scl,
    output logic                          sda_pull,
    input  logic                          sda
);
    import eeprom_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_READY,
        S_WR_START,
        S_CTRL_WR,
        S_ADDR_WR,
        S_DATA_WR,
        S_RD_START,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_ACKN
    } state_t;

    state_t            state;
    bus_phase_t        phase;
    logic [3:0]        bit_cnt;
    logic              is_rd;       // accepted request is a random read
    logic              nack_acc;    // any device ack slot seen high
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] tx_byte;
    logic [DATA_W-1:0] tx_buf;
    logic [DATA_W-1:0] tx_cur;
    logic [DATA_W-1:0] rx_buf;
    logic              byte_state;
    logic              accept;
    logic              tx_step;
    logic              rx_step;
    logic              frame_done;

    // half rate serial clock, flips between the fsm sample points
    always_ff @(negedge CLK)
    begin
        if (RESET)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    // byte to send in the current state
    always_comb
    begin
        case (state)
            S_CTRL_WR: tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1 -: PAGE_W], RW_WRITE};
            S_CTRL_RD: tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1 -: PAGE_W], RW_READ};
            S_ADDR_WR: tx_byte = addr_q[ADDR_W-PAGE_W-1:0];
            default:   tx_byte = wdata_q;
        endcase
    end

    assign byte_state = state inside {S_CTRL_WR, S_ADDR_WR, S_DATA_WR, S_CTRL_RD};
    assign tx_cur     = (bit_cnt == '0) ? tx_byte : tx_buf;  // load on first bit
    assign accept     = (state == S_IDLE) && (wr || rd);
    assign tx_step    = byte_state && (phase == PH_BYTE) && !scl;
    assign rx_step    = (state == S_DATA_RD) && (phase == PH_BYTE) && scl;
    assign frame_done = (state == S_STOP) && scl && sda_pull;

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (tx_step)
            tx_buf <= {tx_cur[DATA_W-2:0], 1'b0};
        if (rx_step)
            rx_buf <= {rx_buf[DATA_W-2:0], sda};  // msb first
        if (frame_done && is_rd)
            rdata <= rx_buf;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            phase    <= PH_IDLE;
            bit_cnt  <= '0;
            is_rd    <= 1'b0;
            nack_acc <= 1'b0;
            sda_pull <= 1'b0;
            ack      <= 1'b0;
            nack     <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        is_rd <= rd && !wr;  // write wins
                        state <= S_READY;
                    end
                end
                S_READY:
                begin
                    bit_cnt  <= '0;
                    nack_acc <= 1'b0;
                    phase    <= PH_START;
                    state    <= S_WR_START;
                end
                S_WR_START, S_RD_START:
                begin
                    if (scl)  // sda falls while scl high
                    begin
                        sda_pull <= 1'b1;
                        phase    <= PH_BYTE;
                        state    <= (state == S_WR_START) ? S_CTRL_WR : S_CTRL_RD;
                    end
                end
                S_CTRL_WR, S_ADDR_WR, S_DATA_WR, S_CTRL_RD:
                begin
                    if (phase == PH_BYTE)
                    begin
                        if (tx_step)
                        begin
                            sda_pull <= !tx_cur[DATA_W-1];
                            bit_cnt  <= bit_cnt + 4'd1;
                        end
                        else if (bit_cnt == 4'(BITS_PER_BYTE))
                        begin
                            bit_cnt <= '0;
                            phase   <= PH_ACK;
                        end
                    end
                    else if (!scl)
                        sda_pull <= 1'b0;  // hand the line to the device
                    else
                    begin
                        nack_acc <= nack_acc | sda;
                        phase    <= PH_BYTE;
                        case (state)
                            S_CTRL_WR: state <= S_ADDR_WR;
                            S_ADDR_WR:
                            begin
                                if (is_rd)
                                begin
                                    phase <= PH_START;
                                    state <= S_RD_START;
                                end
                                else
                                    state <= S_DATA_WR;
                            end
                            S_DATA_WR:
                            begin
                                phase <= PH_STOP;
                                state <= S_STOP;
                            end
                            default: state <= S_DATA_RD;
                        endcase
                    end
                end
                S_DATA_RD:
                begin
                    if (phase == PH_BYTE)
                    begin
                        if (rx_step)
                            bit_cnt <= bit_cnt + 4'd1;
                        else if (bit_cnt == 4'(BITS_PER_BYTE))
                        begin
                            sda_pull <= 1'b0;  // no-ack, single byte only
                            bit_cnt  <= '0;
                            phase    <= PH_ACK;
                        end
                    end
                    else if (scl)
                    begin
                        phase <= PH_STOP;
                        state <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (!scl)
                        sda_pull <= 1'b1;  // low before the stop edge
                    else if (frame_done)
                    begin
                        sda_pull <= 1'b0;
                        ack      <= 1'b1;
                        nack     <= nack_acc;
                        phase    <= PH_IDLE;
                        state    <= S_ACKN;
                    end
                end
                S_ACKN:
                begin
                    ack   <= 1'b0;
                    nack  <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- eeprom_slave.sv
`timescale 1ns/10ps

module eeprom_slave (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic dev_sda_pull
);
    import eeprom_pkg::*;
    import i2c_bus_pkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    bus_phase_t               phase;
    logic                     scl_d;
    logic                     sda_d;
    logic [3:0]               bit_cnt;
    logic [1:0]               byte_idx;  // 0 control, 1 word address, 2 data
    logic                     rd_mode;
    logic                     sending;
    logic [DATA_W-1:0]        shreg;
    logic [DATA_W-1:0]        tx_buf;
    logic [PAGE_W-1:0]        page_q;
    logic [ADDR_W-PAGE_W-1:0] word_q;
    logic [ADDR_W-1:0]        mem_idx;
    logic [DATA_W-1:0]        rd_byte;
    logic                     scl_rise;
    logic                     scl_fall;
    logic                     start_det;
    logic                     stop_det;
    logic                     quiet;
    logic                     rx_bit;
    logic                     rx_done;
    logic                     ack_end;
    logic                     tx_shift;
    logic                     ctrl_match;
    logic                     mem_we;

    assign scl_rise = scl & ~scl_d;
    assign scl_fall = ~scl & scl_d;

    // sda moves mid phase, so a change made while scl high shows up on the next sample
    assign start_det = scl_d & sda_d & ~sda;
    assign stop_det  = scl_d & ~sda_d & sda;
    assign quiet     = ~(start_det | stop_det);

    assign rx_bit   = quiet && (phase == PH_BYTE) && !sending && scl_rise
                      && (bit_cnt < 4'(BITS_PER_BYTE));
    assign rx_done  = quiet && (phase == PH_BYTE) && !sending && scl_fall
                      && (bit_cnt == 4'(BITS_PER_BYTE));
    assign ack_end  = quiet && (phase == PH_ACK) && scl_fall;
    assign tx_shift = quiet && (phase == PH_BYTE) && sending && scl_fall
                      && (bit_cnt < 4'(BITS_PER_BYTE));

    assign ctrl_match = shreg[DATA_W-1 -: $bits(DEVICE_CODE)] == DEVICE_CODE;
    assign mem_we     = rx_done && (byte_idx == 2'd2);
    assign mem_idx    = {page_q, word_q};
    assign rd_byte    = mem[mem_idx];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_d        <= 1'b0;
            sda_d        <= 1'b1;  // idle line is high
            phase        <= PH_IDLE;
            bit_cnt      <= '0;
            byte_idx     <= '0;
            rd_mode      <= 1'b0;
            sending      <= 1'b0;
            dev_sda_pull <= 1'b0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda;
            if (start_det)  // also a repeated start
            begin
                phase        <= PH_BYTE;
                bit_cnt      <= '0;
                byte_idx     <= '0;
                rd_mode      <= 1'b0;
                sending      <= 1'b0;
                dev_sda_pull <= 1'b0;
            end
            else if (stop_det)
            begin
                phase        <= PH_IDLE;
                sending      <= 1'b0;
                dev_sda_pull <= 1'b0;
            end
            else
            begin
                case (phase)
                    PH_BYTE:
                    begin
                        if (rx_bit)
                            bit_cnt <= bit_cnt + 4'd1;
                        else if (rx_done)
                        begin
                            bit_cnt <= '0;
                            if (byte_idx != 2'd0 || ctrl_match)
                            begin
                                dev_sda_pull <= 1'b1;
                                phase        <= PH_ACK;
                            end
                            else
                                phase <= PH_IDLE;  // not for us
                            if (byte_idx == 2'd0)
                                rd_mode <= (shreg[0] == RW_READ);
                        end
                        else if (tx_shift)
                        begin
                            dev_sda_pull <= ~tx_buf[DATA_W-1];
                            bit_cnt      <= bit_cnt + 4'd1;
                        end
                        else if (sending && scl_fall)
                        begin
                            dev_sda_pull <= 1'b0;  // free for the master no-ack
                            sending      <= 1'b0;
                            phase        <= PH_IDLE;
                        end
                    end
                    PH_ACK:
                    begin
                        if (ack_end)
                        begin
                            dev_sda_pull <= 1'b0;
                            if (rd_mode)
                            begin
                                dev_sda_pull <= ~rd_byte[DATA_W-1];  // first read bit
                                bit_cnt      <= 4'd1;
                                sending      <= 1'b1;
                                phase        <= PH_BYTE;
                            end
                            else if (byte_idx == 2'd2)
                                phase <= PH_IDLE;
                            else
                            begin
                                byte_idx <= byte_idx + 2'd1;
                                phase    <= PH_BYTE;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rx_bit)
            shreg <= {shreg[DATA_W-2:0], sda};
        if (rx_done && byte_idx == 2'd0)
            page_q <= shreg[PAGE_W:1];
        if (rx_done && byte_idx == 2'd1)
            word_q <= shreg[ADDR_W-PAGE_W-1:0];
        if (ack_end && rd_mode)
            tx_buf <= {rd_byte[DATA_W-2:0], 1'b0};
        else if (tx_shift)
            tx_buf <= {tx_buf[DATA_W-2:0], 1'b0};
    end

    always_ff @(posedge CLK)
    begin
        if (mem_we)
            mem[mem_idx] <= shreg;
    end

endmodule

//--- eeprom_sys.sv
`timescale 1ns/10ps

module eeprom_sys (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          ack,
    output logic                          nack,
    output logic                          scl,
    output logic                          sda
);

    logic sda_pull;
    logic dev_sda_pull;

    // open drain line, low if either side pulls
    assign sda = ~(sda_pull | dev_sda_pull);

    eeprom_wr u_eeprom_wr (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .nack     (nack),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda      (sda)
    );

    eeprom_slave u_eeprom_slave (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl          (scl),
        .sda          (sda),
        .dev_sda_pull (dev_sda_pull)
    );

endmodule

//--- tb_eeprom_sys.sv
`timescale 1ns/10ps

module tb_eeprom_sys;
    import eeprom_pkg::*;

    localparam int CLK_HALF  = 2;     // 4 ns period
    localparam int RESET_CYC = 5;
    localparam int TIMEOUT   = 400;   // cycles allowed per transaction
    localparam int MAX_CASES = 63;

    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;
    localparam logic [3:0] OP_BOTH  = 4'h3;
    localparam logic [3:0] OP_STRAY = 4'h4;  // write, then extra requests while busy

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              nack;
    logic              scl;
    logic              sda;

    logic [11:0]       cases_mem [256];  // four words per case
    logic [DATA_W-1:0] shadow [MEM_DEPTH];
    logic [7:0]        row;
    integer            seed;
    int                gap;
    int                ack_count = 0;
    int                accepted  = 0;
    int                case_cnt;

    eeprom_sys UUT (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    initial CLK = 1'b0;
    always #CLK_HALF CLK = ~CLK;

    // every ack pulse, accepted or not
    always @(negedge CLK)
    begin
        if (!RESET && ack)
            ack_count <= ack_count + 1;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bus_idle(input string where);
        assert (ack === 1'b0 && nack === 1'b0 && scl === 1'b0 && sda === 1'b1)
        else
            stop_run($sformatf("[ERROR] %0t: bus not idle %s, ack %b nack %b scl %b sda %b",
                               $time, where, ack, nack, scl, sda));
    endtask

    task automatic wait_for_ack(input logic [ADDR_W-1:0] a);
        int cycles;
        cycles = 0;
        while (!ack && cycles < TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (!ack)
            stop_run($sformatf("no acknowledge from the controller within %0d cycles, address %h",
                               TIMEOUT, a));
    endtask

    task automatic run_case(input logic [3:0] op, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] exp);
        @(negedge CLK);
        addr  <= a;
        wdata <= d;
        wr    <= (op != OP_READ);
        rd    <= (op == OP_READ) || (op == OP_BOTH);
        @(negedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        accepted++;
        if (op == OP_STRAY)
        begin
            repeat (3) @(negedge CLK);
            wdata <= ~d;  // must never reach the array
            wr    <= 1'b1;
            rd    <= 1'b1;
            repeat (2) @(negedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
        end
        wait_for_ack(a);
        assert (nack == 1'b0)
        else
            stop_run($sformatf("[ERROR] %0t: nack high, op %h address %h", $time, op, a));
        if (op == OP_READ)
        begin
            assert (rdata == exp)
            else
                stop_run($sformatf("[ERROR] %0t: address %h read %h, expected %h",
                                   $time, a, rdata, exp));
            assert (rdata == shadow[a])
            else
                stop_run($sformatf("[ERROR] %0t: address %h read %h, last written %h",
                                   $time, a, rdata, shadow[a]));
        end
        else
            shadow[a] = d;
    endtask

    initial
    begin
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        seed  = 32'h6397;
        row   = '0;
        repeat (256)
        begin
            cases_mem[row] = '0;  // op 0 ends the list
            row++;
        end
        $readmemh("eeprom_cases.txt", cases_mem);

        for (int i = 0; i < RESET_CYC; i++)
        begin
            @(negedge CLK);
            if (i > 0)
                check_bus_idle("during reset");
        end
        RESET <= 1'b0;
        @(negedge CLK);
        check_bus_idle("after reset");

        row      = '0;
        case_cnt = 0;
        while (cases_mem[row] != '0 && case_cnt < MAX_CASES)
        begin
            if (cases_mem[row] > 12'(OP_STRAY))
                stop_run($sformatf("unknown operation code %h in case %0d",
                                   cases_mem[row], case_cnt));
            run_case(cases_mem[row][3:0], cases_mem[row + 8'd1][ADDR_W-1:0],
                     cases_mem[row + 8'd2][DATA_W-1:0], cases_mem[row + 8'd3][DATA_W-1:0]);
            gap = ($random(seed) & 7) + 1;
            repeat (gap) @(negedge CLK);
            assert (ack_count == accepted)
            else
                stop_run($sformatf("[ERROR] %0t: %0d ack pulses for %0d accepted requests",
                                   $time, ack_count, accepted));
            row = row + 8'd4;
            case_cnt++;
        end

        if (case_cnt == 0)
            stop_run("the cases file held no transactions");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- eeprom_cases.txt
// op addr wdata expect, hex; op 1 write, 2 read, 3 wr and rd together, 4 write with stray requests
// expect is only checked on reads
1 0a5 3c 00
2 0a5 00 3c
1 1a5 c3 00    // same word address, other pages
1 7a5 5a 00
2 0a5 00 3c
2 1a5 00 c3
2 7a5 00 5a
1 0a5 99 00    // rewrite
2 0a5 00 99
3 200 6e 00    // write wins
2 200 00 6e
4 3ff 81 00    // extra pulses while busy
2 3ff 00 81
1 000 ff 00
1 7ff 01 00
2 000 00 ff
2 7ff 00 01
2 1a5 00 c3

//--- files.f
i2c_bus_pkg.sv
eeprom_pkg.sv
eeprom_wr.sv
eeprom_slave.sv
eeprom_sys.sv
tb_eeprom_sys.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP      = tb_eeprom_sys
FILELIST = files.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)
